// ==== include/adc_settings.svh ====
`ifndef ADC_SETTINGS_SVH
`define ADC_SETTINGS_SVH

// capture datapath widths
`define ADC_CHANNELS      8
`define ADC_SAMPLE_BITS   12
`define ADC_LANE_BITS     16
`define ADC_WORD_BITS     128
`define ADC_ADDR_BITS     15  // msb flags address overrun
`define ADC_REC_LEN_BITS  16
`define ADC_DIV_BITS      4

// serial command port
`define ADC_CMD_BITS      24
`define ADC_CODE_BITS     8
`define CODE_HW_RESET     8'hFF
`define CODE_IDLE         8'h00
`define CODE_LOAD         8'h01
`define CODE_SEND         8'h02
`define CODE_SYNC         8'h04

`endif

// ==== logic/adc_pkg.sv ====
`include "adc_settings.svh"

package adc_pkg;

	typedef logic [`ADC_SAMPLE_BITS-1:0]  sample_t;
	typedef logic [`ADC_LANE_BITS-1:0]    lane_t;   // sample or window sum
	typedef sample_t [`ADC_CHANNELS-1:0]  adc_frame_t;  // ch 7 on top
	typedef lane_t [`ADC_CHANNELS-1:0]    lane_frame_t;
	typedef logic [`ADC_WORD_BITS-1:0]    ram_word_t;
	typedef logic [`ADC_ADDR_BITS-1:0]    waddr_t;
	typedef logic [`ADC_REC_LEN_BITS-1:0] rec_len_t;
	typedef logic [`ADC_DIV_BITS-1:0]     div_t;
	typedef logic [`ADC_CMD_BITS-1:0]     serial_cmd_t;
	typedef logic [`ADC_CODE_BITS-1:0]    ctrl_code_t;

	typedef struct packed {
		div_t divisor;  // window is divisor+1 frames
		logic sum_mode;
		logic pack_mode;
	} capture_cfg_t;

	typedef struct packed {
		logic      en;
		logic      wren;
		waddr_t    addr;
		ram_word_t data;
	} ram_wr_t;

	typedef enum logic [1:0] {HW_RESET, IDLE, LOAD, SEND} serial_state_e;

endpackage

// ==== logic/adc_serial_port.sv ====
`timescale 1ns/1ps
`include "adc_settings.svh"

module adc_serial_port
	import adc_pkg::*;
(
	input  logic        adc_clkinp,
	input  logic        reset,
	input  ctrl_code_t  ctrl_code,
	input  serial_cmd_t serial_cmd,
	input  logic        adc_sclk,
	output logic        adc_reset,
	output logic        adc_sen,
	output logic        adc_sdata
);

	logic          sclk_meta, sclk_sync, sclk_last;
	logic          sclk_fall;
	ctrl_code_t    last_code;
	serial_state_e state;
	serial_cmd_t   cmd_buf;
	logic [4:0]    bit_cnt;

	// sync and unknown codes fall back to idle
	function automatic serial_state_e decode_code(input ctrl_code_t code);
		case (code)
			`CODE_HW_RESET: decode_code = HW_RESET;
			`CODE_LOAD:     decode_code = LOAD;
			`CODE_SEND:     decode_code = SEND;
			default:        decode_code = IDLE;
		endcase
	endfunction

	assign sclk_fall = sclk_last & ~sclk_sync;

	always_ff @(posedge adc_clkinp)
	begin
		if (reset)
		begin
			sclk_meta <= 1'b0;
			sclk_sync <= 1'b0;
			sclk_last <= 1'b0;
		end
		else
		begin
			sclk_meta <= adc_sclk;
			sclk_sync <= sclk_meta;
			sclk_last <= sclk_sync;
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (reset)
		begin
			state     <= IDLE;
			last_code <= `CODE_IDLE;
			adc_reset <= 1'b0;
			adc_sen   <= 1'b1;
			adc_sdata <= 1'b0;
			bit_cnt   <= '0;
		end
		else if (sclk_fall)
		begin
			if (ctrl_code != last_code) // new code takes effect from next fall
			begin
				last_code <= ctrl_code;
				state     <= decode_code(ctrl_code);
			end
			case (state)
				HW_RESET:
				begin
					adc_reset <= 1'b1;
					adc_sen   <= 1'b1;
					adc_sdata <= 1'b0;
					bit_cnt   <= '0;
				end
				LOAD:
				begin
					cmd_buf   <= serial_cmd;
					adc_sen   <= 1'b1;
					adc_sdata <= 1'b0;
					bit_cnt   <= '0;
				end
				SEND:
				begin
					if (bit_cnt < `ADC_CMD_BITS)
					begin
						adc_sen   <= 1'b0;
						adc_sdata <= cmd_buf[`ADC_CMD_BITS-1]; // msb first
						cmd_buf   <= {cmd_buf[`ADC_CMD_BITS-2:0], 1'b0};
						bit_cnt   <= bit_cnt + 5'd1;
					end
					else
					begin
						adc_sen   <= 1'b1;  // frame finished
						adc_sdata <= 1'b0;
					end
				end
				default:
				begin
					adc_reset <= 1'b0;
					adc_sen   <= 1'b1;
					adc_sdata <= 1'b0;
					bit_cnt   <= '0;
				end
			endcase
		end
	end

endmodule

// ==== logic/frame_decimator.sv ====
`timescale 1ns/1ps
`include "adc_settings.svh"

module frame_decimator
	import adc_pkg::*;
(
	input  logic         adc_clkinp,
	input  logic         reset,
	input  capture_cfg_t cfg,
	input  logic         recording,
	input  logic         restart,
	input  adc_frame_t   adc_frame,
	input  logic         frame_valid,
	output lane_frame_t  lane_frame,
	output logic         dec_valid
);

	div_t win_cnt;  // frames already taken in the current window
	div_t win_pos;  // window position of the frame offered now
	logic take;
	logic win_close;

	assign take      = frame_valid & recording;
	assign win_pos   = restart ? '0 : win_cnt;  // restart opens a fresh window
	assign win_close = (win_pos == cfg.divisor);

	// control
	always_ff @(posedge adc_clkinp)
	begin
		if (reset)
		begin
			win_cnt   <= '0;
			dec_valid <= 1'b0;
		end
		else
		begin
			dec_valid <= take & win_close;
			if (take)
			begin
				if (win_close)
					win_cnt <= '0;
				else
					win_cnt <= win_pos + 1'b1;
			end
			else if (restart)
				win_cnt <= '0;
		end
	end

	// lane_frame doubles as the running accumulator
	always_ff @(posedge adc_clkinp)
	begin
		if (take)
		begin
			for (int i = 0; i < `ADC_CHANNELS; i++)
			begin
				// pick mode and the first frame of a window start from zero
				lane_frame[i] <= ((cfg.sum_mode && win_pos != '0) ? lane_frame[i] : lane_t'(0))
					+ lane_t'(adc_frame[i]);
			end
		end
	end

endmodule

// ==== logic/sample_packer.sv ====
`timescale 1ns/1ps
`include "adc_settings.svh"

module sample_packer
	import adc_pkg::*;
(
	input  logic        adc_clkinp,
	input  logic        reset,
	input  logic        pack_mode,
	input  logic        restart,
	input  lane_frame_t lane_frame,
	input  logic        dec_valid,
	output ram_word_t   word,
	output logic        word_valid
);

	localparam int GROUP_BITS = `ADC_CHANNELS * `ADC_SAMPLE_BITS;

	logic [1:0]            phase;  // frame position within a 4-frame group
	logic [GROUP_BITS-1:0] group;  // 12-bit samples of this frame, ch 7 first
	logic [GROUP_BITS-1:0] carry;  // leftover stream bits, left aligned

	always_comb
	begin
		for (int i = 0; i < `ADC_CHANNELS; i++)
			group[i*`ADC_SAMPLE_BITS +: `ADC_SAMPLE_BITS] = lane_frame[i][`ADC_SAMPLE_BITS-1:0];
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (reset || restart)
		begin
			phase      <= 2'd0;
			word_valid <= 1'b0;
		end
		else
		begin
			word_valid <= dec_valid & (~pack_mode | (phase != 2'd0));
			if (dec_valid && pack_mode)
				phase <= phase + 2'd1;
		end
	end

	// datapath
	always_ff @(posedge adc_clkinp)
	begin
		if (dec_valid)
		begin
			if (!pack_mode)
				word <= lane_frame;  // lanes as given
			else
			begin
				case (phase)
					2'd0:
						carry <= group;  // no word yet
					2'd1:
					begin
						word  <= {carry, group[95:64]};
						carry <= {group[63:0], 32'b0};
					end
					2'd2:
					begin
						word  <= {carry[95:32], group[95:32]};
						carry <= {group[31:0], 64'b0};
					end
					default:
						word <= {carry[95:64], group};  // group complete
				endcase
			end
		end
	end

endmodule

// ==== logic/record_ctrl.sv ====
`timescale 1ns/1ps
`include "adc_settings.svh"

module record_ctrl
	import adc_pkg::*;
(
	input  logic      adc_clkinp,
	input  logic      reset,
	input  logic      trig,
	input  rec_len_t  rec_length,
	input  ram_word_t word,
	input  logic      word_valid,
	output logic      recording,
	output logic      restart,
	output ram_wr_t   ram,
	output logic      trig_ack,
	output logic      rec_done
);

	logic   triggered;  // one record per reset
	waddr_t wr_cnt;     // words accepted, also the next address
	logic   arm;
	logic   last_write;
	logic   stop;
	logic   accept;

	assign arm = trig & ~triggered;

	// checked in the cycle that writes the word
	assign last_write = ram.wren
		& ((rec_len_t'(wr_cnt) == rec_length) | wr_cnt[`ADC_ADDR_BITS-1]);

	assign stop   = recording & ((rec_length == '0) | last_write);
	assign accept = recording & word_valid & ~stop;  // in-flight words dropped after stop

	always_ff @(posedge adc_clkinp)
	begin
		if (accept)
		begin
			ram.addr <= wr_cnt;
			ram.data <= word;
		end

		if (reset)
		begin
			triggered <= 1'b0;
			recording <= 1'b0;
			restart   <= 1'b0;
			trig_ack  <= 1'b0;
			rec_done  <= 1'b0;
			ram.en    <= 1'b0;
			ram.wren  <= 1'b0;
			wr_cnt    <= '0;
		end
		else
		begin
			restart  <= arm;
			ram.wren <= accept;
			if (accept)
				wr_cnt <= wr_cnt + 1'b1;

			if (arm)
			begin
				triggered <= 1'b1;
				recording <= 1'b1;
				trig_ack  <= 1'b1;
				ram.en    <= 1'b1;
				wr_cnt    <= '0;
			end
			else if (stop)
			begin
				recording <= 1'b0;
				trig_ack  <= 1'b0;
				ram.en    <= 1'b0;
				rec_done  <= 1'b1;  // held until reset
			end
		end
	end

endmodule

// ==== logic/adc_control_top.sv ====
`timescale 1ns/1ps

module adc_control_top
	import adc_pkg::*;
(
	input  logic         adc_clkinp,
	input  logic         reset,
	input  ctrl_code_t   ctrl_code,
	input  serial_cmd_t  serial_cmd,
	input  logic         adc_sclk,
	output logic         adc_reset,
	output logic         adc_sen,
	output logic         adc_sdata,
	input  logic         trig,
	input  rec_len_t     rec_length,
	input  capture_cfg_t cfg,
	input  adc_frame_t   adc_frame,
	input  logic         frame_valid,
	output ram_wr_t      ram,
	output logic         trig_ack,
	output logic         rec_done
);

	logic        recording;
	logic        restart;
	lane_frame_t lane_frame;
	logic        dec_valid;
	ram_word_t   word;
	logic        word_valid;

	// converter configuration
	adc_serial_port u_serial (
		.adc_clkinp (adc_clkinp),
		.reset      (reset),
		.ctrl_code  (ctrl_code),
		.serial_cmd (serial_cmd),
		.adc_sclk   (adc_sclk),
		.adc_reset  (adc_reset),
		.adc_sen    (adc_sen),
		.adc_sdata  (adc_sdata)
	);

	// capture path, frame to ram word
	frame_decimator u_decimator (
		.adc_clkinp  (adc_clkinp),
		.reset       (reset),
		.cfg         (cfg),
		.recording   (recording),
		.restart     (restart),
		.adc_frame   (adc_frame),
		.frame_valid (frame_valid),
		.lane_frame  (lane_frame),
		.dec_valid   (dec_valid)
	);

	sample_packer u_packer (
		.adc_clkinp (adc_clkinp),
		.reset      (reset),
		.pack_mode  (cfg.pack_mode),
		.restart    (restart),
		.lane_frame (lane_frame),
		.dec_valid  (dec_valid),
		.word       (word),
		.word_valid (word_valid)
	);

	record_ctrl u_record (
		.adc_clkinp (adc_clkinp),
		.reset      (reset),
		.trig       (trig),
		.rec_length (rec_length),
		.word       (word),
		.word_valid (word_valid),
		.recording  (recording),
		.restart    (restart),
		.ram        (ram),
		.trig_ack   (trig_ack),
		.rec_done   (rec_done)
	);

endmodule

// ==== bench/tb_adc_control.sv ====
`timescale 1ns/1ps
`include "adc_settings.svh"

module tb_adc_control
	import adc_pkg::*;
();

	logic         adc_clkinp = 1'b0;
	logic         reset;
	ctrl_code_t   ctrl_code;
	serial_cmd_t  serial_cmd;
	logic         adc_sclk;
	logic         adc_reset, adc_sen, adc_sdata;
	logic         trig;
	rec_len_t     rec_length;
	capture_cfg_t cfg;
	adc_frame_t   adc_frame;
	logic         frame_valid;
	ram_wr_t      ram;
	logic         trig_ack, rec_done;

	logic [31:0]  lfsr;
	adc_frame_t   frames_q[$];  // frames sent in this record
	ram_word_t    exp_q[$];     // words the RAM should see
	int           exp_idx;
	logic         armed;        // trig_ack/rec_done handover is checked
	serial_cmd_t  rx_cmd;
	int           rx_bits;

	adc_control_top DUT (.*);

	always #10 adc_clkinp = ~adc_clkinp;

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic sample_t random_sample();
		sample_t v;
		v = '0;
		for (int i = 0; i < `ADC_SAMPLE_BITS; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[`ADC_SAMPLE_BITS-2:0], lfsr[0]};
		end
		return v;
	endfunction

	// expected RAM words from frames_q
	function automatic void build_expected(input capture_cfg_t c, input rec_len_t len);
		lane_frame_t  acc;
		logic [255:0] stream;  // packed bit stream, left aligned
		logic [95:0]  grp;
		int           nbits;
		int           win;
		exp_q.delete();
		acc = '0;
		stream = '0;
		nbits = 0;
		win = 0;
		foreach (frames_q[f])
		begin
			if (win == 0)
				acc = '0;  // new window
			for (int ch = 0; ch < `ADC_CHANNELS; ch++)
			begin
				if (c.sum_mode)
					acc[ch] = acc[ch] + lane_t'(frames_q[f][ch]);  // wraps at 16 bits
				else
					acc[ch] = lane_t'(frames_q[f][ch]);
			end
			if (win < c.divisor)
				win++;
			else
			begin
				win = 0;
				if (!c.pack_mode)
					exp_q.push_back(acc);
				else
				begin
					for (int ch = 0; ch < `ADC_CHANNELS; ch++)
						grp[ch*12 +: 12] = acc[ch][11:0];
					stream = stream | ({grp, 160'b0} >> nbits);
					nbits += 96;
					if (nbits >= 128)
					begin
						exp_q.push_back(stream[255:128]);
						stream = stream << 128;
						nbits -= 128;
					end
				end
			end
		end
		while (exp_q.size() > len)
			exp_q.pop_back();  // record length cuts the tail
	endfunction

	task automatic apply_reset();
		@(negedge adc_clkinp);
		reset = 1'b1;
		armed = 1'b0;
		trig = 1'b0;
		frame_valid = 1'b0;
		adc_sclk = 1'b0;
		ctrl_code = `CODE_IDLE;
		exp_q.delete();
		exp_idx = 0;
		repeat (4) @(negedge adc_clkinp);
		reset = 1'b0;
		assert (!ram.wren && !ram.en && !trig_ack && !rec_done && !DUT.recording)
		else fail_now("record outputs not idle after reset");
		assert (adc_sen && !adc_reset && !adc_sdata && DUT.u_serial.state == IDLE)
		else fail_now("serial port not idle after reset");
	endtask

	task automatic run_capture(input capture_cfg_t c, input rec_len_t len, input int nframes);
		adc_frame_t f;
		int         t;
		apply_reset();
		cfg = c;
		rec_length = len;
		frames_q.delete();
		for (int n = 0; n < nframes; n++)
		begin
			for (int ch = 0; ch < `ADC_CHANNELS; ch++)
				f[ch] = random_sample();
			frames_q.push_back(f);
		end
		build_expected(c, len);
		trig = 1'b1;
		@(negedge adc_clkinp);
		trig = 1'b0;
		armed = 1'b1;
		assert (trig_ack && ram.en && !rec_done)
		else fail_now("trig_ack or ram.en did not rise on trig");
		foreach (frames_q[n])
		begin
			adc_frame = frames_q[n];
			frame_valid = 1'b1;
			@(negedge adc_clkinp);
		end
		frame_valid = 1'b0;
		t = 0;
		while (!rec_done && t < 200)
		begin
			@(negedge adc_clkinp);
			t++;
		end
		assert (rec_done) else fail_now("rec_done did not rise at the end of the record");
		repeat (6) @(negedge adc_clkinp);  // late writes would show up here
		assert (exp_idx == exp_q.size()) else fail_now("fewer RAM writes than expected");
	endtask

	// sclk high for 8 cycles, low for 8, data taken at the rising edge
	task automatic sclk_cycle();
		@(negedge adc_clkinp);
		adc_sclk = 1'b1;
		if (!adc_sen)
		begin
			rx_cmd = {rx_cmd[`ADC_CMD_BITS-2:0], adc_sdata};
			rx_bits++;
		end
		repeat (8) @(negedge adc_clkinp);
		adc_sclk = 1'b0;
		repeat (7) @(negedge adc_clkinp);
	endtask

	always @(posedge adc_clkinp)
	begin
		if (!reset && ram.wren)
		begin
			assert (exp_idx < exp_q.size()) else fail_now("RAM write past the expected record");
			assert (ram.addr == waddr_t'(exp_idx))
			else fail_now($sformatf("ERROR ram.addr: got %h expected %h", ram.addr, exp_idx));
			assert (ram.data == exp_q[exp_idx])
			else fail_now($sformatf("ERROR ram.data: got %h expected %h",
				ram.data, exp_q[exp_idx]));
			exp_idx++;
		end
		if (!reset && armed)
		begin
			assert (trig_ack != rec_done) else fail_now("trig_ack and rec_done out of step");
			assert (ram.en == trig_ack) else fail_now("ram.en and trig_ack out of step");
		end
	end

	initial
	begin
		int t;
		lfsr = 32'h95d3;
		reset = 1'b1;
		ctrl_code = `CODE_IDLE;
		serial_cmd = '0;
		adc_sclk = 1'b0;
		trig = 1'b0;
		rec_length = '0;
		cfg = '0;
		adc_frame = '0;
		frame_valid = 1'b0;
		armed = 1'b0;
		exp_idx = 0;

		run_capture(capture_cfg_t'{4'd0, 1'b0, 1'b0}, 10, 10);  // plain
		run_capture(capture_cfg_t'{4'd2, 1'b0, 1'b0}, 4, 12);   // pick every third
		run_capture(capture_cfg_t'{4'd3, 1'b1, 1'b0}, 3, 12);   // sum of four
		run_capture(capture_cfg_t'{4'd0, 1'b0, 1'b1}, 6, 8);    // dense 12-bit packing

		// record stops at rec_length, second trig ignored
		run_capture(capture_cfg_t'{4'd0, 1'b0, 1'b0}, 5, 10);
		trig = 1'b1;
		@(negedge adc_clkinp);
		trig = 1'b0;
		frame_valid = 1'b1;
		repeat (4) @(negedge adc_clkinp);
		frame_valid = 1'b0;
		repeat (6) @(negedge adc_clkinp);
		assert (rec_done && !trig_ack) else fail_now("second trig restarted the record");

		// serial command
		apply_reset();
		serial_cmd = {random_sample(), random_sample()};
		rx_cmd = '0;
		rx_bits = 0;
		ctrl_code = `CODE_LOAD;
		repeat (3) sclk_cycle();
		ctrl_code = `CODE_SEND;
		t = 0;
		while (rx_bits < `ADC_CMD_BITS && t < 40)
		begin
			sclk_cycle();
			t++;
		end
		repeat (3) sclk_cycle();  // nothing more after the frame
		assert (rx_bits == `ADC_CMD_BITS && adc_sen && !adc_sdata)
		else fail_now("serial frame did not carry exactly 24 bits");
		assert (rx_cmd == serial_cmd)
		else fail_now($sformatf("ERROR adc_sdata: got %h expected %h", rx_cmd, serial_cmd));
		ctrl_code = `CODE_HW_RESET;
		t = 0;
		while (!adc_reset && t < 8)
		begin
			sclk_cycle();
			t++;
		end
		assert (adc_reset) else fail_now("adc_reset did not rise on the hardware reset code");

		$display("all tests passed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+include
logic/adc_pkg.sv
logic/adc_serial_port.sv
logic/frame_decimator.sv
logic/sample_packer.sv
logic/record_ctrl.sv
logic/adc_control_top.sv
bench/tb_adc_control.sv

// ==== Makefile ====
TOP = tb_adc_control

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
